// ==== flist.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/ivalid_array.sv
hdl/itag_array.sv
hdl/itag_hit_compare.sv
hdl/itag_lookup_top.sv
tb/tb_clkgen.sv
tb/tb_itag_lookup.sv

// ==== Makefile ====
SIM     := verilator
TOP     := tb_itag_lookup
FLIST   := flist.f
OBJ_DIR := obj_dir
FLAGS   := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST)) hdl/icache_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_itag_lookup.sv ====
// testbench for the icache tag lookup: random ops checked against a set and way model
`timescale 1ns/1ps
`include "icache_params.svh"

module tb_itag_lookup;

  import icache_pkg::*;

  // ====================================================================
  // run length and signals
  // ====================================================================

  localparam int N_OPS = 2000;
  // at most two cycles per op, plus reset, idle and directed phases
  localparam int MAX_CYCLES = 2 * N_OPS + 1000;

  logic        clk;
  logic        rst_n;
  logic        flush;
  icache_req_t req;
  icache_rsp_t rsp;

  // model of the tag store, [set][way]
  logic [`ICACHE_TAG_W-1:0] m_tag [`ICACHE_N_SET][`ICACHE_N_WAY];
  logic                     m_vld [`ICACHE_N_SET][`ICACHE_N_WAY];
  // expected response per cycle, oldest first
  icache_rsp_t              exp_q [$];
  logic [15:0]              lfsr;
  int                       cycles = 0;
  logic [4:0]               op;

  tb_clkgen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  itag_lookup_top dut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .flush_i (flush),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  // ====================================================================
  // helpers
  // ====================================================================

  // fibonacci lfsr, taps 16 14 13 11, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  // eight tags only, so reads hit often
  function automatic logic [`ICACHE_TAG_W-1:0] pool_tag(input logic [2:0] sel);
    return {17'h1A5C3, sel};
  endfunction

  // half the ops go to the low 8 sets to raise the hit rate
  function automatic icache_idx_t rand_index();
    if (rand_bits(1) != 32'd0) begin
      return icache_idx_t'(rand_bits(6));
    end
    return icache_idx_t'(rand_bits(3));
  endfunction

  function automatic icache_req_t make_req(input logic [`ICACHE_N_WAY-1:0] mask,
                                           input logic we, input logic vbit,
                                           input logic [`ICACHE_TAG_W-1:0] tag,
                                           input icache_idx_t idx);
    icache_req_t r;
    r.way_mask = mask;
    r.we       = we;
    r.vbit     = vbit;
    r.tag      = tag;
    r.index    = idx;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // hit when the way is valid and its tag equals the lookup tag
  function automatic icache_rsp_t model_lookup(input icache_idx_t idx,
                                               input logic [`ICACHE_TAG_W-1:0] tag);
    icache_rsp_t e;
    e       = '0;
    e.valid = 1'b1;
    for (int w = 0; w < `ICACHE_N_WAY; w++) begin
      if (m_vld[idx][w] && m_tag[idx][w] == tag) begin
        e.hit        = 1'b1;
        e.hit_way[w] = 1'b1;
        e.hit_tag    = tag;
      end
    end
    return e;
  endfunction

  // ====================================================================
  // one cycle: drive, update the model, check the previous response
  // ====================================================================

  task automatic step(input icache_req_t r, input logic fl);
    icache_rsp_t e;
    icache_rsp_t got;
    @(posedge clk);
    #1;
    req   = r;
    flush = fl;
    e     = '0;
    if (fl) begin
      for (int s = 0; s < `ICACHE_N_SET; s++) begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
          m_vld[s][w] = 1'b0;
        end
      end
    end else if (r.way_mask != '0) begin
      if (r.we) begin
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
          if (r.way_mask[w]) begin
            m_tag[r.index][w] = r.tag;
            m_vld[r.index][w] = r.vbit;
          end
        end
      end else begin
        e = model_lookup(r.index, r.tag);
      end
    end
    exp_q.push_back(e);
    // response of the op sampled at the edge just passed
    @(negedge clk);
    got = rsp;
    e   = exp_q.pop_front();
    check_value("rsp_o.valid", 32'(got.valid), 32'(e.valid));
    if (e.valid) begin
      check_value("rsp_o.hit", 32'(got.hit), 32'(e.hit));
      check_value("rsp_o.hit_way", 32'(got.hit_way), 32'(e.hit_way));
      check_value("rsp_o.hit_tag", 32'(got.hit_tag), 32'(e.hit_tag));
    end
  endtask

  task automatic random_read();
    logic [`ICACHE_N_WAY-1:0] mask;
    mask = 4'(rand_bits(4)) | 4'h1;
    step(make_req(mask, 1'b0, 1'b0, pool_tag(3'(rand_bits(3))), rand_index()), 1'b0);
  endtask

  // valid writes go to one way only, invalid writes may cover several
  task automatic random_write();
    icache_idx_t              idx;
    logic [`ICACHE_N_WAY-1:0] mask;
    logic [`ICACHE_N_WAY-1:0] dup;
    logic                     vbit;
    logic [`ICACHE_TAG_W-1:0] tag;
    idx  = rand_index();
    tag  = pool_tag(3'(rand_bits(3)));
    vbit = (rand_bits(2) != 32'd0);
    if (vbit) begin
      mask = 4'b0001 << rand_bits(2);
      dup  = '0;
      for (int w = 0; w < `ICACHE_N_WAY; w++) begin
        if (!mask[w] && m_vld[idx][w] && m_tag[idx][w] == tag) begin
          dup[w] = 1'b1;
        end
      end
      // same tag elsewhere in the set is invalidated first
      if (dup != '0) begin
        step(make_req(dup, 1'b1, 1'b0, tag, idx), 1'b0);
      end
    end else begin
      mask = 4'(rand_bits(4));
      if (mask == '0) begin
        mask = 4'hF;
      end
    end
    step(make_req(mask, 1'b1, vbit, tag, idx), 1'b0);
  endtask

  // ====================================================================
  // test sequence
  // ====================================================================

  initial begin
    lfsr  = 16'd48460;
    req   = '0;
    flush = 1'b0;
    for (int s = 0; s < `ICACHE_N_SET; s++) begin
      for (int w = 0; w < `ICACHE_N_WAY; w++) begin
        m_vld[s][w] = 1'b0;
      end
    end
    // nothing is pending before the first step
    exp_q.push_back('0);
    @(posedge rst_n);
    // idle after reset, no response expected
    repeat (8) step('0, 1'b0);
    // every set misses before any write, back to back
    for (int s = 0; s < `ICACHE_N_SET; s++) begin
      step(make_req(4'hF, 1'b0, 1'b0, pool_tag(3'(rand_bits(3))), icache_idx_t'(s)), 1'b0);
    end
    // random mix, roughly 6% flush, 40% write, the rest reads
    for (int i = 0; i < N_OPS; i++) begin
      op = 5'(rand_bits(5));
      if (op < 5'd2) begin
        step('0, 1'b1);
      end else if (op < 5'd15) begin
        random_write();
      end else begin
        random_read();
      end
    end
    // all reads miss after a flush
    step('0, 1'b1);
    repeat (32) random_read();
    // let the last response drain
    step('0, 1'b0);
    $display("Test passed");
    $finish;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== tb/tb_clkgen.sv ====
// testbench clock and reset source: 10 ns clock, reset held low for 10 cycles
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock, 5 ns per phase
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release just after an edge so the DUT never sees it on the edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== hdl/itag_lookup_top.sv ====
// icache tag lookup top: valid array and tag array side by side, feeding the hit compare
`timescale 1ns/1ps
`include "icache_params.svh"

module itag_lookup_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  icache_pkg::icache_req_t req_i,
  output icache_pkg::icache_rsp_t rsp_o
);

  // ====================================================================
  // array read results
  // ====================================================================

  logic [`ICACHE_N_WAY-1:0]                     vbit_w;
  logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0]  tags_w;

  // valid bits, the only array that acts on flush
  ivalid_array u_valid (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .flush_i    (flush_i),
    .way_mask_i (req_i.way_mask),
    .we_i       (req_i.we),
    .vbit_i     (req_i.vbit),
    .index_i    (req_i.index),
    .vbit_o     (vbit_w)
  );

  // tags of all ways
  itag_array u_tag (
    .clk_i      (clk_i),
    .way_mask_i (req_i.way_mask),
    .we_i       (req_i.we),
    .tag_i      (req_i.tag),
    .index_i    (req_i.index),
    .tags_o     (tags_w)
  );

  // hit stage, sees the full request to capture the lookup tag
  itag_hit_compare u_cmp (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req_i),
    .tags_i  (tags_w),
    .vbit_i  (vbit_w),
    .rsp_o   (rsp_o)
  );

endmodule

// ==== hdl/itag_hit_compare.sv ====
// icache hit compare: matches stored tags and valid bits against the lookup tag
`timescale 1ns/1ps
`include "icache_params.svh"

module itag_hit_compare (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  icache_pkg::icache_req_t                      req_i,
  input  logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0]  tags_i,
  input  logic [`ICACHE_N_WAY-1:0]                     vbit_i,
  output icache_pkg::icache_rsp_t                      rsp_o
);

  import icache_pkg::*;

  // ====================================================================
  // lookup stage registers
  // ====================================================================

  // read strobe and tag, aligned with the array read outputs
  logic                     rd_q;
  logic [`ICACHE_TAG_W-1:0] lookup_tag_q;
  // per-way hit
  logic [`ICACHE_N_WAY-1:0] match;
  icache_rsp_t              rsp_d;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_q <= 1'b0;
    end else begin
      rd_q <= (|req_i.way_mask) & ~req_i.we;
    end
  end

  // tag only moves on a read, writes leave it alone
  always_ff @(posedge clk_i) begin
    if ((|req_i.way_mask) && !req_i.we) begin
      lookup_tag_q <= req_i.tag;
    end
  end

  // ====================================================================
  // compare and response
  // ====================================================================

  always_comb begin
    rsp_d       = '0;
    rsp_d.valid = rd_q;
    for (int w = 0; w < `ICACHE_N_WAY; w++) begin
      match[w] = vbit_i[w] & (tags_i[w] == lookup_tag_q);
      // OR-select is enough, at most one way matches
      rsp_d.hit_tag = rsp_d.hit_tag | (tags_i[w] & {`ICACHE_TAG_W{match[w]}});
    end
    rsp_d.hit     = |match;
    rsp_d.hit_way = match;
  end

  assign rsp_o = rsp_d;

  // more than one hit means duplicate valid tags in one set
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) rsp_o.valid |-> $onehot0(rsp_o.hit_way)
  ) else $error("multiple ways hit in one set");

endmodule

// ==== hdl/itag_array.sv ====
// icache tag store: behavioral memory, all ways per word, way-masked writes, registered read
`timescale 1ns/1ps
`include "icache_params.svh"

module itag_array (
  input  logic                                         clk_i,
  input  logic [`ICACHE_N_WAY-1:0]                     way_mask_i,
  input  logic                                         we_i,
  input  logic [`ICACHE_TAG_W-1:0]                     tag_i,
  input  icache_pkg::icache_idx_t                      index_i,
  output logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0]  tags_o
);

  // ====================================================================
  // write path
  // ====================================================================

  // one word per set, way w lives in slice w
  logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0] mem_q [0:`ICACHE_N_SET-1];

  // write data and bit mask, both full word width
  logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0] wr_data;
  logic [`ICACHE_N_WAY-1:0][`ICACHE_TAG_W-1:0] wr_mask;

  logic req_live;
  logic wr_en;
  logic rd_en;

  assign req_live = |way_mask_i;
  assign wr_en    = req_live & we_i;
  assign rd_en    = req_live & ~we_i;

  // same tag goes to every slice, the mask picks the ways
  always_comb begin
    for (int w = 0; w < `ICACHE_N_WAY; w++) begin
      wr_data[w] = tag_i;
      wr_mask[w] = {`ICACHE_TAG_W{way_mask_i[w]}};
    end
  end

  // read-modify-write of the set word
  // unmasked slices keep their old tag
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[index_i] <= (mem_q[index_i] & ~wr_mask) | (wr_data & wr_mask);
    end
  end

  // ====================================================================
  // read path
  // ====================================================================

  // tags of all ways, valid the cycle after the read is sampled
  // holds its value between reads
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      tags_o <= mem_q[index_i];
    end
  end

endmodule

// ==== hdl/ivalid_array.sv ====
// icache valid bit store: one bit per set and way, registered read, single-cycle flush
`timescale 1ns/1ps
`include "icache_params.svh"

module ivalid_array (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  input  logic [`ICACHE_N_WAY-1:0] way_mask_i,
  input  logic                     we_i,
  input  logic                     vbit_i,
  input  icache_pkg::icache_idx_t  index_i,
  output logic [`ICACHE_N_WAY-1:0] vbit_o
);

  // ====================================================================
  // storage
  // ====================================================================

  // valid bits, indexed [set][way]
  logic [`ICACHE_N_SET-1:0][`ICACHE_N_WAY-1:0] valid_q;

  // request strobe from the way mask
  logic req_live;

  assign req_live = |way_mask_i;

  // flush wins over any request in the same cycle
  // a read that meets a flush returns all zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      vbit_o  <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
      vbit_o  <= '0;
    end else if (req_live) begin
      if (we_i) begin
        // only masked ways take the new valid bit
        for (int w = 0; w < `ICACHE_N_WAY; w++) begin
          if (way_mask_i[w]) begin
            valid_q[index_i][w] <= vbit_i;
          end
        end
      end else begin
        // read returns every way of the set
        vbit_o <= valid_q[index_i];
      end
    end
  end

  // ====================================================================
  // checks
  // ====================================================================

  // write enable with no way selected would be silently dropped
  a_write_has_ways: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) we_i |-> req_live
  ) else $error("valid array write with empty way mask");

endmodule

// ==== hdl/icache_pkg.sv ====
// icache lookup types: set index, request and response structs
`include "icache_params.svh"

package icache_pkg;

  // set index, log2 of the set count
  typedef logic [$clog2(`ICACHE_N_SET)-1:0] icache_idx_t;

  // lookup request, 32 bits
  // a nonzero way mask is also the request strobe
  typedef struct packed {
    logic [`ICACHE_N_WAY-1:0] way_mask;
    logic                     we;
    // valid bit stored on a write
    logic                     vbit;
    // write tag, or compare tag on a read
    logic [`ICACHE_TAG_W-1:0] tag;
    icache_idx_t              index;
  } icache_req_t;

  // lookup response, 26 bits
  typedef struct packed {
    logic                     valid;
    logic                     hit;
    // one-hot, zero on a miss
    logic [`ICACHE_N_WAY-1:0] hit_way;
    // tag of the hit way, zero on a miss
    logic [`ICACHE_TAG_W-1:0] hit_tag;
  } icache_rsp_t;

endpackage

// ==== hdl/icache_params.svh ====
// icache tag lookup parameters: way count, set count and tag width
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// ======================================================================
// cache geometry
// ======================================================================

// ways per set, one valid bit and one tag each
`define ICACHE_N_WAY 4

// sets in the tag store, the index width follows from this
`define ICACHE_N_SET 64

// stored tag width in bits
`define ICACHE_TAG_W 20

`endif
